// File: common/lsu_pkg.sv
package lsu_pkg;

    // Bus widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  byte_en_t;

    // Access width, funct3 coding of RISC-V loads and stores
    typedef logic [2:0]  width_t;

    localparam width_t WIDTH_B  = 3'b000;
    localparam width_t WIDTH_H  = 3'b001;
    localparam width_t WIDTH_W  = 3'b010;
    localparam width_t WIDTH_BU = 3'b100;
    localparam width_t WIDTH_HU = 3'b101;

    // Top address nibble of the data RAM
    localparam logic [3:0] REGION_DMEM = 4'h1;

    // Counter block
    localparam addr_t CNT_CYCLE_ADDR = 32'h8000_0010;
    localparam addr_t CNT_CLEAR_ADDR = 32'h8000_0018;
    localparam addr_t CNT_LOAD_ADDR  = 32'h8000_001C;
    localparam addr_t CNT_STORE_ADDR = 32'h8000_0020;

    // Counter returned on a read
    typedef enum logic [1:0] {
        CNT_CYCLE,
        CNT_LOAD,
        CNT_STORE
    } cnt_sel_t;

    // Request fields, held stable from setup to the end of the transfer
    typedef struct packed {
        addr_t  addr;
        data_t  wdata;
        width_t width;
        logic   write;
    } lsu_req_t;

endpackage

// File: dmem/store_align.sv
`timescale 1ns/100ps

module store_align (
    input  logic              [1:0] addr_lo,
    input  lsu_pkg::width_t         width,
    input  lsu_pkg::data_t          wdata,
    output lsu_pkg::byte_en_t       byte_en,
    output lsu_pkg::data_t          wdata_shifted,
    output logic                    misaligned
);

    lsu_pkg::byte_en_t lanes;

    // Data moves up to the addressed byte lane
    assign wdata_shifted = wdata << {addr_lo, 3'b000};

    always_comb begin
        lanes      = '0;
        misaligned = 1'b0;
        case (width)
            lsu_pkg::WIDTH_B, lsu_pkg::WIDTH_BU: begin
                lanes = 4'b0001;
            end
            lsu_pkg::WIDTH_H, lsu_pkg::WIDTH_HU: begin
                lanes      = 4'b0011;
                misaligned = addr_lo[0];
            end
            lsu_pkg::WIDTH_W: begin
                lanes      = 4'b1111;
                misaligned = |addr_lo;
            end
            default: misaligned = 1'b1;
        endcase
        byte_en = misaligned ? 4'b0000 : lanes << addr_lo;
    end

endmodule

// File: dmem/dmem_ram.sv
`timescale 1ns/100ps

module dmem_ram #(
    parameter int DMEM_WORDS = 1024
) (
    input  logic                            clk,
    input  logic                            ram_rd_en,
    input  logic                            ram_wr_en,
    input  logic [$clog2(DMEM_WORDS)-1:0]   index,
    input  lsu_pkg::byte_en_t               byte_en,
    input  lsu_pkg::data_t                  wdata,
    output lsu_pkg::data_t                  rdata
);

    lsu_pkg::data_t mem [DMEM_WORDS];

    // Byte-lane write
    always_ff @(posedge clk) begin
        if (ram_wr_en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byte_en[lane]) begin
                    mem[index][lane*8 +: 8] <= wdata[lane*8 +: 8];
                end
            end
        end
    end

    // Read word available the cycle after the request
    always_ff @(posedge clk) begin
        if (ram_rd_en) begin
            rdata <= mem[index];
        end
    end

endmodule

// File: dmem/load_extract.sv
`timescale 1ns/100ps

module load_extract (
    input  lsu_pkg::data_t        word,
    input  logic            [1:0] addr_lo,
    input  lsu_pkg::width_t       width,
    output lsu_pkg::data_t        ext_data
);

    lsu_pkg::data_t shifted;

    // Addressed byte or halfword brought down to bit 0
    assign shifted = word >> {addr_lo, 3'b000};

    always_comb begin
        case (width)
            lsu_pkg::WIDTH_B: begin
                ext_data = {{24{shifted[7]}}, shifted[7:0]};
            end
            lsu_pkg::WIDTH_H: begin
                ext_data = {{16{shifted[15]}}, shifted[15:0]};
            end
            lsu_pkg::WIDTH_BU: begin
                ext_data = {24'h00_0000, shifted[7:0]};
            end
            lsu_pkg::WIDTH_HU: begin
                ext_data = {16'h0000, shifted[15:0]};
            end
            // Word, and illegal widths which end in an error anyway
            default: begin
                ext_data = word;
            end
        endcase
    end

endmodule

// File: hw/perf_counters.sv
`timescale 1ns/100ps

module perf_counters (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cnt_clear,
    input  logic              load_done,
    input  logic              store_done,
    input  lsu_pkg::cnt_sel_t cnt_sel,
    output lsu_pkg::data_t    cnt_data
);

    lsu_pkg::data_t cycle_cnt;
    lsu_pkg::data_t load_cnt;
    lsu_pkg::data_t store_cnt;

    // Clear wins over any increment in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle_cnt <= '0;
            load_cnt  <= '0;
            store_cnt <= '0;
        end else if (cnt_clear) begin
            cycle_cnt <= '0;
            load_cnt  <= '0;
            store_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 32'd1;
            if (load_done) begin
                load_cnt <= load_cnt + 32'd1;
            end
            if (store_done) begin
                store_cnt <= store_cnt + 32'd1;
            end
        end
    end

    always_comb begin
        case (cnt_sel)
            lsu_pkg::CNT_CYCLE: cnt_data = cycle_cnt;
            lsu_pkg::CNT_LOAD:  cnt_data = load_cnt;
            lsu_pkg::CNT_STORE: cnt_data = store_cnt;
            default:            cnt_data = '0;
        endcase
    end

    // One transfer at a time, so a load and a store never finish together
    assert property (@(posedge clk) disable iff (!arst_n)
        !(load_done && store_done));

endmodule

// File: hw/lsu_ctrl.sv
`timescale 1ns/100ps

module lsu_ctrl #(
    parameter int DMEM_WORDS = 1024
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                psel,
    input  logic                penable,
    input  lsu_pkg::lsu_req_t   req,
    input  logic                misaligned,
    input  lsu_pkg::data_t      ext_data,
    input  lsu_pkg::data_t      cnt_data,
    output logic                pready,
    output logic                pslverr,
    output lsu_pkg::data_t      prdata,
    output logic                ram_rd_en,
    output logic                ram_wr_en,
    output lsu_pkg::cnt_sel_t   cnt_sel,
    output logic                cnt_clear,
    output logic                load_done,
    output logic                store_done
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        READ_DATA
    } ctrl_state_t;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        in_dmem;
    logic        is_cycle;
    logic        is_clear;
    logic        is_load;
    logic        is_store;
    logic        access_err;
    logic        in_access;

    if ((DMEM_WORDS & (DMEM_WORDS - 1)) != 0 || DMEM_WORDS > 2**26) begin : g_bad_depth
        $error("DMEM_WORDS must be a power of two no larger than 2^26");
    end

    // Address decode
    assign in_dmem  = req.addr[31:28] == lsu_pkg::REGION_DMEM;
    assign is_cycle = req.addr == lsu_pkg::CNT_CYCLE_ADDR;
    assign is_clear = req.addr == lsu_pkg::CNT_CLEAR_ADDR;
    assign is_load  = req.addr == lsu_pkg::CNT_LOAD_ADDR;
    assign is_store = req.addr == lsu_pkg::CNT_STORE_ADDR;

    // Unmapped, bad width or alignment, wrong direction on a counter
    assign access_err = misaligned
                     || !(in_dmem || is_cycle || is_clear || is_load || is_store)
                     || (req.write && (is_cycle || is_load || is_store))
                     || (!req.write && is_clear);

    assign in_access = state == ACCESS;

    assign ram_rd_en = in_access && in_dmem && !req.write && !access_err;
    assign ram_wr_en = in_access && in_dmem && req.write && !access_err;

    // RAM reads take one wait state, everything else ends at once
    assign pready     = (in_access && !ram_rd_en) || state == READ_DATA;
    assign pslverr    = in_access && access_err;
    assign prdata     = (state == READ_DATA) ? ext_data : cnt_data;
    assign load_done  = state == READ_DATA;
    assign store_done = ram_wr_en;
    assign cnt_clear  = in_access && is_clear && req.write && !access_err;

    always_comb begin
        if (is_load) begin
            cnt_sel = lsu_pkg::CNT_LOAD;
        end else if (is_store) begin
            cnt_sel = lsu_pkg::CNT_STORE;
        end else begin
            cnt_sel = lsu_pkg::CNT_CYCLE;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // Setup cycle seen
                if (psel && !penable) begin
                    state_nxt = ACCESS;
                end
            end
            ACCESS:    state_nxt = ram_rd_en ? READ_DATA : IDLE;
            READ_DATA: state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Transfer completes only inside a requester's access phase
    assert property (@(posedge clk) disable iff (!arst_n)
        pready |-> (psel && penable));

    assert property (@(posedge clk) disable iff (!arst_n)
        !(ram_wr_en && ram_rd_en));

endmodule

// File: hw/lsu_top.sv
`timescale 1ns/100ps

module lsu_top #(
    parameter int DMEM_WORDS = 1024
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              psel,
    input  logic              penable,
    input  lsu_pkg::lsu_req_t req,
    output logic              pready,
    output logic              pslverr,
    output lsu_pkg::data_t    prdata
);

    logic                ram_rd_en;
    logic                ram_wr_en;
    logic                misaligned;
    lsu_pkg::byte_en_t   byte_en;
    lsu_pkg::data_t      wdata_shifted;
    lsu_pkg::data_t      ram_rdata;
    lsu_pkg::data_t      ext_data;
    lsu_pkg::data_t      cnt_data;
    lsu_pkg::cnt_sel_t   cnt_sel;
    logic                cnt_clear;
    logic                load_done;
    logic                store_done;

    lsu_ctrl #(
        .DMEM_WORDS(DMEM_WORDS)
    ) lsu_ctrl_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .psel       (psel),
        .penable    (penable),
        .req        (req),
        .misaligned (misaligned),
        .ext_data   (ext_data),
        .cnt_data   (cnt_data),
        .pready     (pready),
        .pslverr    (pslverr),
        .prdata     (prdata),
        .ram_rd_en  (ram_rd_en),
        .ram_wr_en  (ram_wr_en),
        .cnt_sel    (cnt_sel),
        .cnt_clear  (cnt_clear),
        .load_done  (load_done),
        .store_done (store_done)
    );

    perf_counters perf_counters_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .cnt_clear  (cnt_clear),
        .load_done  (load_done),
        .store_done (store_done),
        .cnt_sel    (cnt_sel),
        .cnt_data   (cnt_data)
    );

    store_align store_align_i (
        .addr_lo       (req.addr[1:0]),
        .width         (req.width),
        .wdata         (req.wdata),
        .byte_en       (byte_en),
        .wdata_shifted (wdata_shifted),
        .misaligned    (misaligned)
    );

    // Word index wraps at the RAM depth
    dmem_ram #(
        .DMEM_WORDS(DMEM_WORDS)
    ) dmem_ram_i (
        .clk       (clk),
        .ram_rd_en (ram_rd_en),
        .ram_wr_en (ram_wr_en),
        .index     (req.addr[$clog2(DMEM_WORDS)+1:2]),
        .byte_en   (byte_en),
        .wdata     (wdata_shifted),
        .rdata     (ram_rdata)
    );

    load_extract load_extract_i (
        .word     (ram_rdata),
        .addr_lo  (req.addr[1:0]),
        .width    (req.width),
        .ext_data (ext_data)
    );

endmodule

// File: testbench/lsu_checker.sv
`timescale 1ns/100ps

module lsu_checker #(
    parameter int DMEM_WORDS = 1024
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              psel,
    input  logic              penable,
    input  lsu_pkg::lsu_req_t req,
    input  logic              pready,
    input  logic              pslverr,
    input  lsu_pkg::data_t    prdata,
    output int                err_count,
    output int                check_count
);

    localparam int DMEM_BYTES = 4 * DMEM_WORDS;

    logic [7:0]     shadow_mem [DMEM_BYTES];
    lsu_pkg::data_t shadow_cycle  = '0;
    lsu_pkg::data_t shadow_loads  = '0;
    lsu_pkg::data_t shadow_stores = '0;
    lsu_pkg::data_t last_cycle    = '0;
    logic           have_cycle    = 1'b0;
    logic           cleared       = 1'b0;
    int             errors        = 0;
    int             checks        = 0;
    // Wait states of the transfer in progress
    int             waits         = 0;

    assign err_count   = errors;
    assign check_count = checks;

    function automatic int byte_index(input lsu_pkg::addr_t a);
        return int'(a % 32'(DMEM_BYTES));
    endfunction

    // Expected {pslverr, prdata} from the shadow state
    function automatic logic [32:0] expect_resp(input lsu_pkg::lsu_req_t r);
        lsu_pkg::addr_t a;
        int             idx;
        logic           in_dmem;
        logic           err;
        lsu_pkg::data_t d;
        a       = r.addr;
        idx     = byte_index(a);
        in_dmem = a[31:28] == lsu_pkg::REGION_DMEM;
        err = !(r.width inside {lsu_pkg::WIDTH_B, lsu_pkg::WIDTH_H, lsu_pkg::WIDTH_W,
                                lsu_pkg::WIDTH_BU, lsu_pkg::WIDTH_HU});
        err = err || ((r.width == lsu_pkg::WIDTH_H || r.width == lsu_pkg::WIDTH_HU) && a[0]);
        err = err || (r.width == lsu_pkg::WIDTH_W && a[1:0] != 2'b00);
        err = err || !(in_dmem || a inside {lsu_pkg::CNT_CYCLE_ADDR, lsu_pkg::CNT_CLEAR_ADDR,
                                            lsu_pkg::CNT_LOAD_ADDR, lsu_pkg::CNT_STORE_ADDR});
        err = err || (r.write && a inside {lsu_pkg::CNT_CYCLE_ADDR, lsu_pkg::CNT_LOAD_ADDR,
                                           lsu_pkg::CNT_STORE_ADDR});
        err = err || (!r.write && a == lsu_pkg::CNT_CLEAR_ADDR);
        d = '0;
        if (!err && in_dmem) begin
            case (r.width)
                lsu_pkg::WIDTH_B:  d = {{24{shadow_mem[idx][7]}}, shadow_mem[idx]};
                lsu_pkg::WIDTH_BU: d = {24'h00_0000, shadow_mem[idx]};
                lsu_pkg::WIDTH_H: begin
                    d = {{16{shadow_mem[idx+1][7]}}, shadow_mem[idx+1], shadow_mem[idx]};
                end
                lsu_pkg::WIDTH_HU: d = {16'h0000, shadow_mem[idx+1], shadow_mem[idx]};
                default: begin
                    d = {shadow_mem[idx+3], shadow_mem[idx+2], shadow_mem[idx+1], shadow_mem[idx]};
                end
            endcase
        end else if (!err && a == lsu_pkg::CNT_CYCLE_ADDR) begin
            d = shadow_cycle;
        end else if (!err && a == lsu_pkg::CNT_LOAD_ADDR) begin
            d = shadow_loads;
        end else if (!err && a == lsu_pkg::CNT_STORE_ADDR) begin
            d = shadow_stores;
        end
        return {err, d};
    endfunction

    task automatic store_shadow(input lsu_pkg::lsu_req_t r);
        int idx;
        int nbytes;
        idx = byte_index(r.addr);
        case (r.width)
            lsu_pkg::WIDTH_B, lsu_pkg::WIDTH_BU: nbytes = 1;
            lsu_pkg::WIDTH_H, lsu_pkg::WIDTH_HU: nbytes = 2;
            default:                             nbytes = 4;
        endcase
        for (int k = 0; k < nbytes; k++) begin
            shadow_mem[idx + k] = r.wdata[k*8 +: 8];
        end
    endtask

    // Successive cycle reads rise unless a clear came between them
    task automatic check_cycle_order(input lsu_pkg::data_t value);
        if (have_cycle && !cleared && value <= last_cycle) begin
            errors++;
            $display("cycle counter did not increase between two reads");
        end
        if (have_cycle && cleared && value >= last_cycle) begin
            errors++;
            $display("cycle counter read after a clear is not below the read before it");
        end
        last_cycle = value;
        have_cycle = 1'b1;
        cleared    = 1'b0;
    endtask

    always @(posedge clk or negedge arst_n) begin : compare
        logic [32:0] expected;
        logic        clear_now;
        int          exp_waits;
        if (!arst_n) begin
            shadow_cycle  = '0;
            shadow_loads  = '0;
            shadow_stores = '0;
            waits         = 0;
        end else begin
            clear_now = 1'b0;
            if (psel && penable && !pready) begin
                waits++;
            end
            if (psel && penable && pready) begin
                expected = expect_resp(req);
                checks++;
                // One wait state only for a legal RAM read
                exp_waits = (!expected[32] && !req.write
                             && req.addr[31:28] == lsu_pkg::REGION_DMEM) ? 1 : 0;
                if (waits != exp_waits) begin
                    errors++;
                    $display("** Error: pready wait states expected %h got %h, address %h",
                             exp_waits, waits, req.addr);
                end
                waits = 0;
                if (pslverr !== expected[32]) begin
                    errors++;
                    $display("** Error: pslverr expected %h got %h, address %h",
                             expected[32], pslverr, req.addr);
                end else if (!expected[32] && !req.write && prdata !== expected[31:0]) begin
                    errors++;
                    $display("** Error: prdata expected %h got %h, address %h",
                             expected[31:0], prdata, req.addr);
                end
                if (!expected[32]) begin
                    if (req.addr[31:28] == lsu_pkg::REGION_DMEM) begin
                        if (req.write) begin
                            store_shadow(req);
                            shadow_stores = shadow_stores + 32'd1;
                        end else begin
                            shadow_loads = shadow_loads + 32'd1;
                        end
                    end else if (!req.write && req.addr == lsu_pkg::CNT_CYCLE_ADDR) begin
                        check_cycle_order(prdata);
                    end else if (req.write) begin
                        clear_now = 1'b1;
                    end
                end
            end
            // Counters follow the DUT one edge later
            if (clear_now) begin
                shadow_cycle  = '0;
                shadow_loads  = '0;
                shadow_stores = '0;
                cleared       = 1'b1;
            end else begin
                shadow_cycle = shadow_cycle + 32'd1;
            end
        end
    end

endmodule

// File: testbench/tb_top.sv
`timescale 1ns/100ps

module tb_top;

    localparam int DMEM_WORDS = 1024;

    logic              clk = 1'b0;
    logic              arst_n;
    logic              psel;
    logic              penable;
    lsu_pkg::lsu_req_t req;
    logic              pready;
    logic              pslverr;
    lsu_pkg::data_t    prdata;
    logic [15:0]       lfsr = 16'd56674;
    int                err_count;
    int                check_count;
    int                timeouts = 0;

    always #5 clk = ~clk;

    lsu_top #(
        .DMEM_WORDS(DMEM_WORDS)
    ) lsu_top_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .req     (req),
        .pready  (pready),
        .pslverr (pslverr),
        .prdata  (prdata)
    );

    lsu_checker #(
        .DMEM_WORDS(DMEM_WORDS)
    ) lsu_checker_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .psel        (psel),
        .penable     (penable),
        .req         (req),
        .pready      (pready),
        .pslverr     (pslverr),
        .prdata      (prdata),
        .err_count   (err_count),
        .check_count (check_count)
    );

    // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic lsu_pkg::width_t rand_width();
        logic [31:0] r;
        r = rand_bits(2);
        case (r[1:0])
            2'd0:    return lsu_pkg::WIDTH_B;
            2'd1:    return lsu_pkg::WIDTH_H;
            default: return lsu_pkg::WIDTH_W;
        endcase
    endfunction

    // Random RAM address aligned for the width with upper bits that exercise the wrap
    function automatic lsu_pkg::addr_t rand_ram_addr(input lsu_pkg::width_t w);
        logic [31:0] r;
        r = rand_bits(28);
        r = {lsu_pkg::REGION_DMEM, r[27:0]};
        if (w == lsu_pkg::WIDTH_W) begin
            r[1:0] = 2'b00;
        end else if (w == lsu_pkg::WIDTH_H) begin
            r[0] = 1'b0;
        end
        return r;
    endfunction

    task automatic wait_ready();
        int n;
        n = 0;
        @(posedge clk);
        while (!pready && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!pready) begin
            $display("timeout, pready did not arrive within 20 cycles at address %h", req.addr);
            timeouts++;
        end
    endtask

    task automatic transfer(input lsu_pkg::addr_t addr, input lsu_pkg::data_t wdata,
                            input lsu_pkg::width_t width, input logic write);
        // A stuck DUT ends the stimulus
        if (timeouts == 0) begin
            @(negedge clk);
            psel    = 1'b1;
            penable = 1'b0;
            req     = '{addr: addr, wdata: wdata, width: width, write: write};
            @(negedge clk);
            penable = 1'b1;
            wait_ready();
            @(negedge clk);
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    task automatic read_counter(input lsu_pkg::addr_t addr);
        transfer(addr, 32'd0, lsu_pkg::WIDTH_W, 1'b0);
    endtask

    initial begin
        lsu_pkg::addr_t  a;
        lsu_pkg::addr_t  base;
        lsu_pkg::width_t w;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        req     = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Fill every RAM word so later reads see known data
        for (int i = 0; i < DMEM_WORDS; i++) begin
            transfer(32'h1000_0000 + 32'(i) * 32'd4, rand_bits(32), lsu_pkg::WIDTH_W, 1'b1);
        end

        // Random stores each read back at every width
        for (int i = 0; i < 200; i++) begin
            w = rand_width();
            a = rand_ram_addr(w);
            transfer(a, rand_bits(32), w, 1'b1);
            transfer(a, 32'd0, lsu_pkg::WIDTH_B, 1'b0);
            transfer(a, 32'd0, lsu_pkg::WIDTH_BU, 1'b0);
            transfer({a[31:1], 1'b0}, 32'd0, lsu_pkg::WIDTH_H, 1'b0);
            transfer({a[31:1], 1'b0}, 32'd0, lsu_pkg::WIDTH_HU, 1'b0);
            transfer({a[31:2], 2'b00}, 32'd0, lsu_pkg::WIDTH_W, 1'b0);
        end
        read_counter(lsu_pkg::CNT_LOAD_ADDR);
        read_counter(lsu_pkg::CNT_STORE_ADDR);

        // Misaligned, illegal width and unmapped accesses leave the word unchanged
        for (int i = 0; i < 20; i++) begin
            base = rand_ram_addr(lsu_pkg::WIDTH_W);
            transfer(base + 32'd1, rand_bits(32), lsu_pkg::WIDTH_H, 1'b1);
            transfer(base + 32'd3, rand_bits(32), lsu_pkg::WIDTH_HU, 1'b1);
            transfer(base + 32'd2, rand_bits(32), lsu_pkg::WIDTH_W, 1'b1);
            transfer(base + 32'd1, 32'd0, lsu_pkg::WIDTH_W, 1'b0);
            transfer(base, rand_bits(32), 3'b011, 1'b1);
            transfer(base, rand_bits(32), 3'b110, 1'b1);
            transfer(base, 32'd0, 3'b111, 1'b0);
            transfer(base ^ 32'h3000_0000, rand_bits(32), lsu_pkg::WIDTH_W, 1'b1);
            transfer(base, 32'd0, lsu_pkg::WIDTH_W, 1'b0);
        end
        read_counter(32'h8000_0014);
        read_counter(32'h8000_0000);
        read_counter(lsu_pkg::CNT_LOAD_ADDR);
        read_counter(lsu_pkg::CNT_STORE_ADDR);

        // Wrong direction on counter addresses
        transfer(lsu_pkg::CNT_CYCLE_ADDR, rand_bits(32), lsu_pkg::WIDTH_W, 1'b1);
        transfer(lsu_pkg::CNT_LOAD_ADDR, rand_bits(32), lsu_pkg::WIDTH_W, 1'b1);
        transfer(lsu_pkg::CNT_STORE_ADDR, rand_bits(32), lsu_pkg::WIDTH_W, 1'b1);
        read_counter(lsu_pkg::CNT_CLEAR_ADDR);

        // Cycle counter rises and restarts after a clear
        read_counter(lsu_pkg::CNT_CYCLE_ADDR);
        read_counter(lsu_pkg::CNT_CYCLE_ADDR);
        transfer(lsu_pkg::CNT_CLEAR_ADDR, 32'd0, lsu_pkg::WIDTH_W, 1'b1);
        read_counter(lsu_pkg::CNT_LOAD_ADDR);
        read_counter(lsu_pkg::CNT_STORE_ADDR);
        read_counter(lsu_pkg::CNT_CYCLE_ADDR);
        for (int i = 0; i < 5; i++) begin
            a = rand_ram_addr(lsu_pkg::WIDTH_W);
            transfer(a, rand_bits(32), lsu_pkg::WIDTH_W, 1'b1);
            transfer(a, 32'd0, lsu_pkg::WIDTH_W, 1'b0);
            transfer(a, 32'd0, lsu_pkg::WIDTH_BU, 1'b0);
        end
        read_counter(lsu_pkg::CNT_LOAD_ADDR);
        read_counter(lsu_pkg::CNT_STORE_ADDR);
        read_counter(lsu_pkg::CNT_CYCLE_ADDR);

        @(negedge clk);
        $display("checks: %0d, errors: %0d", check_count, err_count + timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: tb.f
common/lsu_pkg.sv
dmem/store_align.sv
dmem/dmem_ram.sv
dmem/load_extract.sv
hw/perf_counters.sv
hw/lsu_ctrl.sv
hw/lsu_top.sv
testbench/lsu_checker.sv
testbench/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
